// ==== design/pulse_gate.sv ====
//////////////////////////////////////////////////////////////////////
// millisecond prescaler and interval counter giving the pulse gate
//////////////////////////////////////////////////////////////////////

module pulse_gate #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int SAMP_RATE = 1_000_000,
  parameter int PW_MS     = 2,
  parameter int PRI_MS    = 10
) (
  input  logic clk,
  input  logic rst,
  output logic gate_on_o
);

  import timing_pkg::*;

  localparam int MS_CYC = cycles_per_ms(CLK_FREQ);
  localparam int TICK_W = tick_cnt_bits(CLK_FREQ);
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(MS_CYC - 1);
  localparam logic [MS_CNT_BITS-1:0] PRI_LAST = MS_CNT_BITS'(PRI_MS - 1);
  localparam logic [MS_CNT_BITS-1:0] PW_CNT = MS_CNT_BITS'(PW_MS);

  logic [TICK_W-1:0]      pre_q;
  logic                   ms_tick;
  logic [MS_CNT_BITS-1:0] ms_q;
  logic [MS_CNT_BITS-1:0] ms_nxt;

  assign ms_tick = (pre_q == TICK_LAST);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pre_q <= '0;
    end else if (ms_tick) begin
      pre_q <= '0;
    end else begin
      pre_q <= pre_q + 1'b1;
    end
  end

  // milliseconds into the current repetition interval
  always_comb begin
    ms_nxt = ms_q;
    if (ms_tick) begin
      ms_nxt = (ms_q == PRI_LAST) ? '0 : ms_q + 1'b1;
    end
  end

  // compare against the next count so the gate edge sits on the tick edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ms_q      <= '0;
      gate_on_o <= 1'b1;  // count starts at 0, inside the pulse
    end else begin
      ms_q      <= ms_nxt;
      gate_on_o <= (ms_nxt < PW_CNT);
    end
  end

  a_pw_fits : assert property (@(posedge clk) PW_MS <= PRI_MS)
    else $error("pulse width %0d ms exceeds interval %0d ms", PW_MS, PRI_MS);

  // gate edges must fall on sample boundaries of the strobe generator
  a_ms_aligned : assert property (@(posedge clk) (MS_CYC % (CLK_FREQ / SAMP_RATE)) == 0)
    else $error("millisecond is not a whole number of sample periods");

endmodule

// ==== design/pulsed_sine.sv ====
//////////////////////////////////////////////////////////////////////
// pulsed sine tone generator, phase accumulator and output gating
// instances the sample strobe, the sine table and the pulse gate
//////////////////////////////////////////////////////////////////////

module pulsed_sine #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int SAMP_RATE = 1_000_000,
  parameter int TONE_FREQ = 10_000,
  parameter int PW_MS     = 2,
  parameter int PRI_MS    = 10,
  parameter int DW        = tone_pkg::SAMPLE_W
) (
  input  logic              clk,
  input  logic              rst,
  output tone_pkg::sample_t sample_o
);

  import tone_pkg::*;

  // truncated increment of table size * fraction steps * f_tone / f_samp
  localparam longint INC_FULL =
    longint'(LUT_SIZE) * longint'(2 ** ADDR_FRAC_BITS) * longint'(TONE_FREQ)
    / longint'(SAMP_RATE);
  localparam logic [PHASE_BITS-1:0] PHASE_INC = PHASE_BITS'(INC_FULL);

  logic                     sample_en;  // one cycle per sample
  logic [PHASE_BITS-1:0]    phase_q;
  logic [LUT_ADDR_BITS-1:0] lut_addr;
  logic signed [DW-1:0]     lut_sample;
  logic                     gate_on;
  logic                     gate_q;     // gate as seen at the strobe edge
  logic                     valid_q;

  // phase accumulator
  // the table registers the current index at the same edge
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase_q <= '0;
    end else if (sample_en) begin
      phase_q <= phase_q + PHASE_INC;  // wraps modulo one tone period
    end
  end

  assign lut_addr = phase_q[PHASE_BITS-1 -: LUT_ADDR_BITS];  // drop fraction bits

  // output stage aligned with the table read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= 1'b0;
      gate_q  <= 1'b0;
    end else begin
      valid_q <= sample_en;
      if (sample_en) begin
        gate_q <= gate_on;
      end
    end
  end

  // samples outside the pulse are zero but still marked valid
  always_comb begin
    sample_o.valid = valid_q;
    sample_o.data  = gate_q ? lut_sample : '0;
  end

  sample_strobe_gen #(
    .CLK_FREQ  (CLK_FREQ),
    .SAMP_RATE (SAMP_RATE)
  ) u_strobe (
    .clk  (clk),
    .rst  (rst),
    .en_o (sample_en)
  );

  sine_lut #(
    .DW (DW)
  ) u_lut (
    .clk      (clk),
    .rst      (rst),
    .rd_en_i  (sample_en),
    .addr_i   (lut_addr),
    .sample_o (lut_sample)
  );

  pulse_gate #(
    .CLK_FREQ  (CLK_FREQ),
    .SAMP_RATE (SAMP_RATE),
    .PW_MS     (PW_MS),
    .PRI_MS    (PRI_MS)
  ) u_gate (
    .clk       (clk),
    .rst       (rst),
    .gate_on_o (gate_on)
  );

  // table width has to fill the sample struct exactly
  a_dw_match : assert property (@(posedge clk) DW == SAMPLE_W)
    else $error("table width %0d differs from sample width %0d", DW, SAMPLE_W);

  // a strobe taken with the gate off gives a valid zero sample
  a_gated_zero : assert property (@(posedge clk) disable iff (rst)
    (sample_en && !gate_on) |=> (sample_o.valid && sample_o.data == '0))
    else $error("nonzero sample outside the pulse");

endmodule

// ==== design/sample_strobe_gen.sv ====
//////////////////////////////////////////////////////////////////////
// one-cycle strobe at the sample rate, divided from the clock
//////////////////////////////////////////////////////////////////////

module sample_strobe_gen #(
  parameter int CLK_FREQ  = 100_000_000,
  parameter int SAMP_RATE = 1_000_000
) (
  input  logic clk,
  input  logic rst,
  output logic en_o
);

  localparam int DIV = CLK_FREQ / SAMP_RATE;
  localparam int CNT_W = ($clog2(DIV) > 0) ? $clog2(DIV) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIV - 1);

  logic [CNT_W-1:0] cnt_q;

  // down-counter, first strobe lands DIV cycles after reset release
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_q <= RELOAD;
      en_o  <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q <= RELOAD;
      en_o  <= 1'b1;
    end else begin
      cnt_q <= cnt_q - 1'b1;
      en_o  <= 1'b0;
    end
  end

  // a ratio below 2 would leave the strobe stuck high
  a_div_ratio : assert property (@(posedge clk) DIV >= 2)
    else $error("sample strobe division ratio %0d below 2", DIV);

  a_single_cycle : assert property (@(posedge clk) disable iff (rst) en_o |=> !en_o)
    else $error("sample strobe high on consecutive cycles");

endmodule

// ==== design/sine_lut.sv ====
//////////////////////////////////////////////////////////////////////
// registered signed sine table, one full period, filled at elaboration
//////////////////////////////////////////////////////////////////////

module sine_lut #(
  parameter int DW = tone_pkg::SAMPLE_W
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                rd_en_i,
  input  logic [tone_pkg::LUT_ADDR_BITS-1:0]  addr_i,
  output logic signed [DW-1:0]                sample_o
);

  import tone_pkg::*;

  localparam real PI = 3.14159265358979323846;
  localparam real AMPL = real'((2 ** (DW - 1)) - 1);  // full scale, symmetric

  // entry k = round(sin(2*pi*k/N) * AMPL), ties away from zero
  function automatic logic signed [DW-1:0] sine_entry(input int k);
    real angle;
    real scaled;
    int  rounded;
    angle  = 2.0 * PI * real'(k) / real'(LUT_SIZE);
    scaled = $sin(angle) * AMPL;
    if (scaled >= 0.0) begin
      rounded = $rtoi(scaled + 0.5);
    end else begin
      rounded = -$rtoi(0.5 - scaled);
    end
    return DW'(rounded);
  endfunction

  logic signed [DW-1:0] table_q [LUT_SIZE];

  // constant contents, maps to a ROM
  for (genvar k = 0; k < LUT_SIZE; k++) begin : g_fill
    localparam logic signed [DW-1:0] ENTRY = sine_entry(k);
    assign table_q[k] = ENTRY;
  end

  // one cycle read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sample_o <= '0;
    end else if (rd_en_i) begin
      sample_o <= table_q[addr_i];
    end
  end

endmodule

// ==== design/timing_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// millisecond timebase derivation and pulse timing counter widths
//////////////////////////////////////////////////////////////////////

package timing_pkg;

  localparam int MS_PER_SEC = 1000;

  // interval counter, counts milliseconds inside one repetition interval
  localparam int MS_CNT_BITS = 16;

  // clock cycles in one millisecond
  function automatic int cycles_per_ms(input int clk_freq);
    return clk_freq / MS_PER_SEC;
  endfunction

  // prescaler width, never below one bit
  function automatic int tick_cnt_bits(input int clk_freq);
    int n;
    n = $clog2(cycles_per_ms(clk_freq));
    return (n > 0) ? n : 1;
  endfunction

endpackage

// ==== design/tone_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// tone sample format, sine table geometry and output sample struct
//////////////////////////////////////////////////////////////////////

package tone_pkg;

  // sample format
  localparam int SAMPLE_W = 16;  // default data width, signed

  // table geometry
  localparam int LUT_ADDR_BITS = 8;
  localparam int LUT_SIZE = 2 ** LUT_ADDR_BITS;

  // phase accumulator holds the table index plus extra fraction bits
  // so that slow tones still step smoothly through the table
  localparam int ADDR_FRAC_BITS = 4;
  localparam int PHASE_BITS = LUT_ADDR_BITS + ADDR_FRAC_BITS;

  // one output sample, valid at the sample rate even when gated off
  typedef struct packed {
    logic                       valid;
    logic signed [SAMPLE_W-1:0] data;
  } sample_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pulsed sine testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log
EXE=Vtb_pulsed_sine

verilator --binary --timing --assert -j 0 \
  --top-module tb_pulsed_sine -f src.f \
  --Mdir "$BUILD_DIR" -o "$EXE"

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
  echo "simulation reported failure, see $LOG"
  exit 1
fi
exit 0

// ==== src.f ====
design/tone_pkg.sv
design/timing_pkg.sv
design/sample_strobe_gen.sv
design/sine_lut.sv
design/pulse_gate.sv
design/pulsed_sine.sv
verification/tb_clock_gen.sv
verification/tb_pulsed_sine.sv

// ==== verification/tb_clock_gen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock and power-on reset, reset re-entered on request
//////////////////////////////////////////////////////////////////////

module tb_clock_gen #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 2,
  parameter int DRIVE_DLY  = 10
) (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // reset spans RST_CYCLES rising edges, released just after the last one
  initial begin
    rst_o = 1'b1;
    forever begin
      repeat (RST_CYCLES) @(posedge clk_o);
      #(DRIVE_DLY);
      rst_o = 1'b0;
      @(posedge rst_req_i);  // request comes a short delay after an edge
      rst_o = 1'b1;
    end
  end

endmodule

// ==== verification/tb_pulsed_sine.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the pulsed sine generator, with a cycle model of
// strobe cadence, phase, sine table and pulse gate
//////////////////////////////////////////////////////////////////////

module tb_pulsed_sine;

  import tone_pkg::*;
  import timing_pkg::*;

  localparam int CLK_FREQ  = 200_000;
  localparam int SAMP_RATE = 20_000;
  localparam int TONE_FREQ = 1250;
  localparam int PW_MS     = 2;
  localparam int PRI_MS    = 5;

  localparam int  DRIVE_DLY = 10;
  localparam int  SAMP_DIV  = CLK_FREQ / SAMP_RATE;  // cycles per sample
  localparam int  MS_CYC    = CLK_FREQ / MS_PER_SEC;
  localparam int  PRI_CYC   = PRI_MS * MS_CYC;
  localparam int  LUT_N     = 256;
  localparam int  FRAC_N    = 16;                    // phase steps per table entry
  localparam int  PHASE_MOD = LUT_N * FRAC_N;
  localparam int  PHASE_INC = LUT_N * FRAC_N * TONE_FREQ / SAMP_RATE;
  localparam real PI        = 3.14159265358979323846;
  localparam real AMPL      = real'((1 << (SAMPLE_W - 1)) - 1);

  localparam int RELEASE_TIMEOUT = 10;
  localparam int VALID_TIMEOUT   = 2 * SAMP_DIV;

  logic    clk;
  logic    rst;
  logic    rst_req;
  sample_t dut_sample;

  int seed;
  int mismatches;
  int timeouts;
  int checks;
  int cyc;          // rising edges since the last reset release
  int model_phase;
  int last_valid;
  bit timed_out;
  int lut_model [LUT_N];

  tb_clock_gen #(
    .PERIOD     (100),
    .RST_CYCLES (2),
    .DRIVE_DLY  (DRIVE_DLY)
  ) u_clk (
    .rst_req_i (rst_req),
    .clk_o     (clk),
    .rst_o     (rst)
  );

  pulsed_sine #(
    .CLK_FREQ  (CLK_FREQ),
    .SAMP_RATE (SAMP_RATE),
    .TONE_FREQ (TONE_FREQ),
    .PW_MS     (PW_MS),
    .PRI_MS    (PRI_MS)
  ) UUT (
    .clk      (clk),
    .rst      (rst),
    .sample_o (dut_sample)
  );

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 'h7fff_ffff;
    return lo + (r % (hi - lo + 1));
  endfunction

  // rounded, scaled sine over one period
  function automatic void build_sine_model();
    for (int k = 0; k < LUT_N; k++) begin
      lut_model[k] = int'($sin(2.0 * PI * real'(k) / real'(LUT_N)) * AMPL);
    end
  endfunction

  // gate level after rising edge c of the current run
  function automatic int gate_expected(input int c);
    return (((c / MS_CYC) % PRI_MS) < PW_MS) ? 1 : 0;
  endfunction

  task automatic check_value(input string name, input int expected, input int actual);
    checks++;
    if (expected != actual) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %0d, actual %0d", $time, name, expected,
               actual);
    end
  endtask

  task automatic check_cycle();
    int         exp_valid;
    int         exp_data;
    logic [7:0] idx;
    exp_valid = (cyc >= SAMP_DIV + 1 && (cyc - 1) % SAMP_DIV == 0) ? 1 : 0;
    check_value("sample_o.valid", exp_valid, int'(dut_sample.valid));
    check_value("gate_on", gate_expected(cyc), int'(UUT.gate_on));
    if (dut_sample.valid) begin
      if (last_valid >= 0) begin
        check_value("valid spacing", SAMP_DIV, cyc - last_valid);
      end
      last_valid = cyc;
    end
    if (exp_valid == 1) begin
      idx = 8'(model_phase / FRAC_N);
      // gate is taken one edge before the table read
      exp_data = (gate_expected(cyc - 1) == 1) ? lut_model[idx] : 0;
      check_value("sample_o.data", exp_data, int'(dut_sample.data));
      model_phase = (model_phase + PHASE_INC) % PHASE_MOD;
    end
  endtask

  // outputs are read at the falling edge, away from the update edge
  task automatic step_cycle();
    @(negedge clk);
    cyc++;
    check_cycle();
  endtask

  task automatic wait_release();
    bit released;
    released = 1'b0;
    for (int i = 0; i < RELEASE_TIMEOUT && !released; i++) begin
      @(negedge clk);
      rst_req = 1'b0;
      if (!rst) begin
        released = 1'b1;
      end else begin
        check_value("sample_o.valid in reset", 0, int'(dut_sample.valid));
      end
    end
    if (!released) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout at %0t: reset not released within %0d cycles", $time,
               RELEASE_TIMEOUT);
    end else begin
      cyc         = 0;
      model_phase = 0;
      last_valid  = -1;
      check_cycle();
    end
  endtask

  task automatic wait_first_valid();
    bit seen;
    seen = 1'b0;
    for (int i = 0; i < VALID_TIMEOUT && !seen; i++) begin
      step_cycle();
      seen = dut_sample.valid;
    end
    if (!seen) begin
      timeouts++;
      timed_out = 1'b1;
      $display("Timeout at %0t: no valid sample within %0d cycles of reset release",
               $time, VALID_TIMEOUT);
    end
  endtask

  task automatic request_reset();
    @(posedge clk);
    #(DRIVE_DLY);
    rst_req = 1'b1;
  endtask

  initial begin
    int run_intervals;
    int n_resets;
    int seg_len;
    rst_req     = 1'b0;
    seed        = 83;
    mismatches  = 0;
    timeouts    = 0;
    checks      = 0;
    cyc         = 0;
    model_phase = 0;
    last_valid  = -1;
    timed_out   = 1'b0;
    build_sine_model();
    run_intervals = rand_range(2, 4);
    n_resets      = rand_range(1, 3);
    $display("run of %0d intervals, %0d mid-run resets", run_intervals, n_resets);

    for (int seg = 0; seg <= n_resets && !timed_out; seg++) begin
      wait_release();
      if (!timed_out) begin
        wait_first_valid();
      end
      if (!timed_out) begin
        // first run covers whole intervals, later ones stop mid-interval
        seg_len = (seg == 0) ? run_intervals * PRI_CYC + rand_range(0, MS_CYC - 1)
                             : rand_range(MS_CYC, 2 * PRI_CYC);
        while (cyc < seg_len) begin
          step_cycle();
        end
        if (seg < n_resets) begin
          request_reset();
        end
      end
    end

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
